/* design/lc3b_isa_pkg.sv */
`default_nettype none

package lc3b_isa_pkg;

    localparam int WORD_W   = 16;  // data and address width
    localparam int REG_W    = 3;   // register index width
    localparam int NUM_REGS = 8;

    // opcodes of the supported subset
    localparam logic [3:0] OP_BR  = 4'b0000;
    localparam logic [3:0] OP_ADD = 4'b0001;
    localparam logic [3:0] OP_AND = 4'b0101;
    localparam logic [3:0] OP_NOT = 4'b1001;
    localparam logic [3:0] OP_STR = 4'b0111;

    // One instruction word seen two ways. ADD, AND and NOT use the operate
    // view, BR and STR the offset view. offset9 of a BR is {base, offset6}.
    typedef union packed {
        struct packed {
            logic [3:0]       opcode;
            logic [REG_W-1:0] dest;
            logic [REG_W-1:0] src1;
            logic             imm_flag;  // 1 selects imm5
            logic [4:0]       tail;      // src2 in [2:0] or imm5
        } op;
        struct packed {
            logic [3:0]       opcode;
            logic [REG_W-1:0] nzp;       // branch mask or store source
            logic [REG_W-1:0] base;
            logic [5:0]       offset6;
        } off;
    } lc3b_instr_t;

endpackage

`default_nettype wire

/* design/lc3b_core_pkg.sv */
`default_nettype none

package lc3b_core_pkg;

    localparam logic [15:0] RESET_PC = 16'h3000;  // first fetch address
    localparam int          CNT_W    = 16;        // perf counter width

    // ALU operation codes, decode to execute
    localparam logic [1:0] ALU_ADD  = 2'b00;
    localparam logic [1:0] ALU_AND  = 2'b01;
    localparam logic [1:0] ALU_NOT  = 2'b10;
    localparam logic [1:0] ALU_PASS = 2'b11;  // operand b straight through

    localparam logic [2:0] CC_RESET = 3'b010;  // Z

endpackage

`default_nettype wire

/* design/regfile.sv */
`default_nettype none

module regfile
    import lc3b_isa_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              wr_en,
    input  logic [REG_W-1:0]  wr_dest,
    input  logic [WORD_W-1:0] wr_data,
    input  logic [REG_W-1:0]  rd_idx_a,
    input  logic [REG_W-1:0]  rd_idx_b,
    output logic [WORD_W-1:0] rd_val_a,
    output logic [WORD_W-1:0] rd_val_b
);

    logic [WORD_W-1:0] regs [NUM_REGS];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < NUM_REGS; i++)
                regs[i] <= '0;
        end
        else if (wr_en)
            regs[wr_dest] <= wr_data;
    end

    // write-through, covers a producer two slots ahead
    assign rd_val_a = (wr_en && wr_dest == rd_idx_a) ? wr_data : regs[rd_idx_a];
    assign rd_val_b = (wr_en && wr_dest == rd_idx_b) ? wr_data : regs[rd_idx_b];

    wr_en_known: assert property (@(posedge clk) disable iff (rst) !$isunknown(wr_en));

endmodule

`default_nettype wire

/* design/fetch_unit.sv */
`default_nettype none

module fetch_unit
    import lc3b_isa_pkg::*, lc3b_core_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              redirect,
    input  logic [WORD_W-1:0] redirect_pc,
    input  logic [WORD_W-1:0] instr_rdata,
    output logic [WORD_W-1:0] instr_address,
    output logic              id_valid,
    output logic [WORD_W-1:0] id_ir,
    output logic [WORD_W-1:0] id_pc_next
);

    logic [WORD_W-1:0] pc;
    logic [WORD_W-1:0] pc_plus2;

    assign pc_plus2      = pc + WORD_W'(2);
    assign instr_address = pc;  // ROM answers in the same cycle

    always_ff @(posedge clk)
    begin
        if (rst)
            pc <= RESET_PC;
        else if (redirect)
            pc <= redirect_pc;  // taken branch from execute
        else
            pc <= pc_plus2;
    end

    always_ff @(posedge clk)
    begin
        if (rst || redirect)
            id_valid <= 1'b0;  // word fetched now is on the wrong path
        else
            id_valid <= 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (!redirect)
        begin
            id_ir      <= instr_rdata;
            id_pc_next <= pc_plus2;
        end
    end

    flush_clears_decode: assert property (@(posedge clk) disable iff (rst)
        redirect |=> !id_valid);

endmodule

`default_nettype wire

/* design/decode_unit.sv */
`default_nettype none

module decode_unit
    import lc3b_isa_pkg::*, lc3b_core_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              flush,
    input  logic              id_valid,
    input  logic [WORD_W-1:0] id_ir,
    input  logic [WORD_W-1:0] id_pc_next,
    input  logic              wb_valid,
    input  logic [REG_W-1:0]  wb_dest,
    input  logic [WORD_W-1:0] wb_data,
    output logic              ex_valid,
    output logic [1:0]        ex_alu_op,
    output logic              ex_is_branch,
    output logic              ex_is_store,
    output logic              ex_writes_reg,
    output logic              ex_sets_cc,
    output logic [REG_W-1:0]  ex_dest,
    output logic [REG_W-1:0]  ex_src1_idx,
    output logic [REG_W-1:0]  ex_src2_idx,
    output logic [WORD_W-1:0] ex_src1_val,
    output logic [WORD_W-1:0] ex_src2_val,
    output logic              ex_use_imm,
    output logic [WORD_W-1:0] ex_imm,
    output logic [2:0]        ex_nzp,
    output logic [WORD_W-1:0] ex_pc_next
);

    lc3b_instr_t       instr;
    logic [WORD_W-1:0] imm5_sext;
    logic [WORD_W-1:0] off6_adj;
    logic [WORD_W-1:0] off9_adj;
    logic [8:0]        off9;
    logic [1:0]        dec_alu_op;
    logic              dec_is_branch;
    logic              dec_is_store;
    logic              dec_writes_reg;
    logic              dec_sets_cc;
    logic              dec_use_imm;
    logic [REG_W-1:0]  dec_src1;
    logic [REG_W-1:0]  dec_src2;
    logic [WORD_W-1:0] dec_imm;
    logic [WORD_W-1:0] src1_val;
    logic [WORD_W-1:0] src2_val;

    assign instr     = id_ir;
    assign off9      = {instr.off.base, instr.off.offset6};
    assign imm5_sext = {{(WORD_W-5){instr.op.tail[4]}}, instr.op.tail};
    assign off6_adj  = {{(WORD_W-7){instr.off.offset6[5]}}, instr.off.offset6, 1'b0};
    assign off9_adj  = {{(WORD_W-10){off9[8]}}, off9, 1'b0};

    always_comb
    begin
        dec_alu_op     = ALU_PASS;
        dec_is_branch  = 1'b0;
        dec_is_store   = 1'b0;
        dec_writes_reg = 1'b0;
        dec_sets_cc    = 1'b0;
        dec_use_imm    = 1'b0;
        dec_src1       = instr.op.src1;  // same bits as the STR base
        dec_src2       = instr.op.tail[REG_W-1:0];
        dec_imm        = imm5_sext;
        case (instr.op.opcode)
            OP_ADD, OP_AND:
            begin
                dec_alu_op     = (instr.op.opcode == OP_ADD) ? ALU_ADD : ALU_AND;
                dec_writes_reg = 1'b1;
                dec_sets_cc    = 1'b1;
                dec_use_imm    = instr.op.imm_flag;
            end
            OP_NOT:
            begin
                dec_alu_op     = ALU_NOT;
                dec_writes_reg = 1'b1;
                dec_sets_cc    = 1'b1;
            end
            OP_BR:
            begin
                dec_is_branch = |instr.off.nzp;  // nzp 000 is a NOP
                dec_imm       = off9_adj;
            end
            OP_STR:
            begin
                dec_is_store = 1'b1;
                dec_src2     = instr.off.nzp;  // store source on port b
                dec_imm      = off6_adj;
            end
            default: ;  // unknown opcode retires as a NOP
        endcase
    end

    regfile regfile_inst (
        .clk(clk), .rst(rst),
        .wr_en(wb_valid), .wr_dest(wb_dest), .wr_data(wb_data),
        .rd_idx_a(dec_src1), .rd_idx_b(dec_src2),
        .rd_val_a(src1_val), .rd_val_b(src2_val)
    );

    always_ff @(posedge clk)
    begin
        if (rst || flush || !id_valid)
        begin
            ex_valid      <= 1'b0;  // bubble
            ex_is_branch  <= 1'b0;
            ex_is_store   <= 1'b0;
            ex_writes_reg <= 1'b0;
            ex_sets_cc    <= 1'b0;
        end
        else
        begin
            ex_valid      <= 1'b1;
            ex_is_branch  <= dec_is_branch;
            ex_is_store   <= dec_is_store;
            ex_writes_reg <= dec_writes_reg;
            ex_sets_cc    <= dec_sets_cc;
        end
        ex_alu_op   <= dec_alu_op;
        ex_dest     <= instr.op.dest;
        ex_src1_idx <= dec_src1;
        ex_src2_idx <= dec_src2;
        ex_src1_val <= src1_val;
        ex_src2_val <= src2_val;
        ex_use_imm  <= dec_use_imm;
        ex_imm      <= dec_imm;
        ex_nzp      <= instr.off.nzp;
        ex_pc_next  <= id_pc_next;
    end

endmodule

`default_nettype wire

/* design/execute_unit.sv */
`default_nettype none

module execute_unit
    import lc3b_isa_pkg::*, lc3b_core_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              ex_valid,
    input  logic [1:0]        ex_alu_op,
    input  logic              ex_is_branch,
    input  logic              ex_is_store,
    input  logic              ex_writes_reg,
    input  logic              ex_sets_cc,
    input  logic [REG_W-1:0]  ex_dest,
    input  logic [REG_W-1:0]  ex_src1_idx,
    input  logic [REG_W-1:0]  ex_src2_idx,
    input  logic [WORD_W-1:0] ex_src1_val,
    input  logic [WORD_W-1:0] ex_src2_val,
    input  logic              ex_use_imm,
    input  logic [WORD_W-1:0] ex_imm,
    input  logic [2:0]        ex_nzp,
    input  logic [WORD_W-1:0] ex_pc_next,
    output logic              redirect,
    output logic [WORD_W-1:0] redirect_pc,
    output logic              wb_valid,
    output logic [REG_W-1:0]  wb_dest,
    output logic [WORD_W-1:0] wb_data,
    output logic              mem_write,
    output logic [WORD_W-1:0] mem_address,
    output logic [WORD_W-1:0] mem_wdata,
    output logic              wb_retire,
    output logic              ex_branch
);

    logic [WORD_W-1:0] opnd_a;
    logic [WORD_W-1:0] src2_fwd;
    logic [WORD_W-1:0] opnd_b;
    logic [WORD_W-1:0] alu_out;
    logic [WORD_W-1:0] store_addr;
    logic [2:0]        gen_cc;
    logic [2:0]        cc;

    // only the writeback register can be newer than the regfile read
    assign opnd_a   = (wb_valid && wb_dest == ex_src1_idx) ? wb_data : ex_src1_val;
    assign src2_fwd = (wb_valid && wb_dest == ex_src2_idx) ? wb_data : ex_src2_val;
    assign opnd_b   = ex_use_imm ? ex_imm : src2_fwd;

    always_comb
    begin
        case (ex_alu_op)
            ALU_ADD: alu_out = opnd_a + opnd_b;
            ALU_AND: alu_out = opnd_a & opnd_b;
            ALU_NOT: alu_out = ~opnd_a;
            default: alu_out = opnd_b;  // store data for STR
        endcase
    end

    always_comb
    begin
        if (alu_out[WORD_W-1])
            gen_cc = 3'b100;
        else if (alu_out == '0)
            gen_cc = 3'b010;
        else
            gen_cc = 3'b001;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            cc <= CC_RESET;
        else if (ex_valid && ex_sets_cc)
            cc <= gen_cc;  // visible to a branch right behind
    end

    // predicted not taken, so only a taken branch redirects
    assign ex_branch   = ex_valid && ex_is_branch;
    assign redirect    = ex_branch && |(ex_nzp & cc);
    assign redirect_pc = ex_pc_next + ex_imm;
    assign store_addr  = opnd_a + ex_imm;  // base + offset6 << 1

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wb_valid  <= 1'b0;
            wb_retire <= 1'b0;
            mem_write <= 1'b0;
        end
        else
        begin
            wb_valid  <= ex_valid && ex_writes_reg;
            wb_retire <= ex_valid;  // NOPs retire too
            mem_write <= ex_valid && ex_is_store;
        end
        wb_dest     <= ex_dest;
        wb_data     <= alu_out;
        mem_address <= store_addr;
        mem_wdata   <= alu_out;
    end

    store_or_reg_write: assert property (@(posedge clk) disable iff (rst)
        !(mem_write && wb_valid));

endmodule

`default_nettype wire

/* design/perf_counters.sv */
`default_nettype none

module perf_counters
    import lc3b_core_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             wb_retire,
    input  logic             ex_branch,
    output logic [CNT_W-1:0] instr_count,
    output logic [CNT_W-1:0] branch_count
);

    always_ff @(posedge clk)
    begin
        if (rst)
            instr_count <= '0;
        else if (wb_retire)
            instr_count <= instr_count + 1'b1;  // wraps
    end

    // counts executed branches, taken or not
    always_ff @(posedge clk)
    begin
        if (rst)
            branch_count <= '0;
        else if (ex_branch)
            branch_count <= branch_count + 1'b1;
    end

endmodule

`default_nettype wire

/* design/lc3b_core.sv */
`default_nettype none

module lc3b_core
    import lc3b_isa_pkg::*, lc3b_core_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    output logic [WORD_W-1:0] instr_address,
    input  logic [WORD_W-1:0] instr_rdata,
    output logic              mem_write,
    output logic [WORD_W-1:0] mem_address,
    output logic [WORD_W-1:0] mem_wdata,
    output logic [CNT_W-1:0]  instr_count,
    output logic [CNT_W-1:0]  branch_count
);

    logic              id_valid;
    logic [WORD_W-1:0] id_ir;
    logic [WORD_W-1:0] id_pc_next;
    logic              ex_valid;
    logic [1:0]        ex_alu_op;
    logic              ex_is_branch;
    logic              ex_is_store;
    logic              ex_writes_reg;
    logic              ex_sets_cc;
    logic [REG_W-1:0]  ex_dest;
    logic [REG_W-1:0]  ex_src1_idx;
    logic [REG_W-1:0]  ex_src2_idx;
    logic [WORD_W-1:0] ex_src1_val;
    logic [WORD_W-1:0] ex_src2_val;
    logic              ex_use_imm;
    logic [WORD_W-1:0] ex_imm;
    logic [2:0]        ex_nzp;
    logic [WORD_W-1:0] ex_pc_next;
    logic              redirect;
    logic [WORD_W-1:0] redirect_pc;
    logic              wb_valid;
    logic [REG_W-1:0]  wb_dest;
    logic [WORD_W-1:0] wb_data;
    logic              wb_retire;
    logic              ex_branch;

    fetch_unit fetch_unit_inst (
        .clk(clk), .rst(rst),
        .redirect(redirect), .redirect_pc(redirect_pc),
        .instr_rdata(instr_rdata), .instr_address(instr_address),
        .id_valid(id_valid), .id_ir(id_ir), .id_pc_next(id_pc_next)
    );

    // a taken branch also squashes the word in decode
    decode_unit decode_unit_inst (
        .clk(clk), .rst(rst), .flush(redirect),
        .id_valid(id_valid), .id_ir(id_ir), .id_pc_next(id_pc_next),
        .wb_valid(wb_valid), .wb_dest(wb_dest), .wb_data(wb_data),
        .ex_valid(ex_valid), .ex_alu_op(ex_alu_op),
        .ex_is_branch(ex_is_branch), .ex_is_store(ex_is_store),
        .ex_writes_reg(ex_writes_reg), .ex_sets_cc(ex_sets_cc),
        .ex_dest(ex_dest), .ex_src1_idx(ex_src1_idx), .ex_src2_idx(ex_src2_idx),
        .ex_src1_val(ex_src1_val), .ex_src2_val(ex_src2_val),
        .ex_use_imm(ex_use_imm), .ex_imm(ex_imm), .ex_nzp(ex_nzp),
        .ex_pc_next(ex_pc_next)
    );

    execute_unit execute_unit_inst (
        .clk(clk), .rst(rst),
        .ex_valid(ex_valid), .ex_alu_op(ex_alu_op),
        .ex_is_branch(ex_is_branch), .ex_is_store(ex_is_store),
        .ex_writes_reg(ex_writes_reg), .ex_sets_cc(ex_sets_cc),
        .ex_dest(ex_dest), .ex_src1_idx(ex_src1_idx), .ex_src2_idx(ex_src2_idx),
        .ex_src1_val(ex_src1_val), .ex_src2_val(ex_src2_val),
        .ex_use_imm(ex_use_imm), .ex_imm(ex_imm), .ex_nzp(ex_nzp),
        .ex_pc_next(ex_pc_next),
        .redirect(redirect), .redirect_pc(redirect_pc),
        .wb_valid(wb_valid), .wb_dest(wb_dest), .wb_data(wb_data),
        .mem_write(mem_write), .mem_address(mem_address), .mem_wdata(mem_wdata),
        .wb_retire(wb_retire), .ex_branch(ex_branch)
    );

    perf_counters perf_counters_inst (
        .clk(clk), .rst(rst),
        .wb_retire(wb_retire), .ex_branch(ex_branch),
        .instr_count(instr_count), .branch_count(branch_count)
    );

endmodule

`default_nettype wire

/* test/lc3b_program.svh */
`ifndef LC3B_PROGRAM_SVH
`define LC3B_PROGRAM_SVH

// one word per row from RESET_PC on, the comment gives the effect
task automatic load_program();
    append_word(alu_imm_word(OP_ADD, 3'd6, 3'd6, 15));    // r6 = 000f
    append_word(alu_imm_word(OP_ADD, 3'd6, 3'd6, 1));     // r6 = 0010, back to back
    append_word(alu_imm_word(OP_ADD, 3'd1, 3'd1, 5));     // r1 = 0005
    append_word(alu_imm_word(OP_ADD, 3'd2, 3'd2, -3));    // r2 = fffd
    append_word(alu_reg_word(OP_ADD, 3'd3, 3'd1, 3'd2));  // r3 = 0002, r1 two apart
    append_word(store_word(3'd3, 3'd6, 0));               // [0010] = 0002
    append_word(alu_reg_word(OP_AND, 3'd4, 3'd2, 3'd1));  // r4 = 0005
    append_word(alu_imm_word(OP_AND, 3'd5, 3'd2, -2));    // r5 = fffc
    append_word(not_word(3'd7, 3'd5));                    // r7 = 0003, back to back
    append_word(store_word(3'd4, 3'd6, 1));               // [0012] = 0005
    append_word(store_word(3'd7, 3'd6, -1));              // [000e] = 0003
    append_word(store_word(3'd5, 3'd6, 31));              // [004e] = fffc
    // taken on n, then z falls through
    append_word(alu_imm_word(OP_ADD, 3'd1, 3'd1, -8));    // r1 = fffd, cc n
    append_word(branch_word(3'b100, 2));
    append_word(store_word(3'd1, 3'd6, 2));               // squashed
    append_word(store_word(3'd1, 3'd6, 3));               // squashed
    append_word(store_word(3'd1, 3'd6, 4));               // [0018] = fffd
    append_word(branch_word(3'b010, 2));                  // not taken
    append_word(store_word(3'd1, 3'd6, 5));               // [001a] = fffd
    // taken on z
    append_word(alu_imm_word(OP_AND, 3'd2, 3'd2, 0));     // r2 = 0000, cc z
    append_word(branch_word(3'b010, 2));
    append_word(store_word(3'd2, 3'd6, 6));               // squashed
    append_word(store_word(3'd2, 3'd6, 7));               // squashed
    append_word(store_word(3'd2, 3'd6, -2));              // [000c] = 0000
    // taken on p, then nz falls through onto a NOP
    append_word(alu_imm_word(OP_ADD, 3'd3, 3'd2, 7));     // r3 = 0007, cc p
    append_word(branch_word(3'b001, 2));
    append_word(store_word(3'd3, 3'd6, 8));               // squashed
    append_word(store_word(3'd3, 3'd6, 9));               // squashed
    append_word(store_word(3'd3, 3'd6, 10));              // [0024] = 0007
    append_word(branch_word(3'b110, 2));                  // not taken
    append_word(branch_word(3'b000, 0));                  // nzp 000 is a NOP
    append_word(store_word(3'd3, 3'd6, 11));              // [0026] = 0007
    append_word(branch_word(3'b111, -1));                 // spins on itself
    append_word(branch_word(3'b000, 0));                  // fetched behind the spin
    append_word(branch_word(3'b000, 0));
endtask

// address, data, then both counters as seen during the strobe
task automatic load_expected();
    expect_store(16'h0010, 16'h0002, 16'd5, 16'd0);
    expect_store(16'h0012, 16'h0005, 16'd9, 16'd0);
    expect_store(16'h000e, 16'h0003, 16'd10, 16'd0);
    expect_store(16'h004e, 16'hfffc, 16'd11, 16'd0);
    expect_store(16'h0018, 16'hfffd, 16'd14, 16'd1);  // two squashed words not counted
    expect_store(16'h001a, 16'hfffd, 16'd16, 16'd2);
    expect_store(16'h000c, 16'h0000, 16'd19, 16'd3);
    expect_store(16'h0024, 16'h0007, 16'd22, 16'd4);
    expect_store(16'h0026, 16'h0007, 16'd25, 16'd5);  // NOP counted, not as a branch
endtask

`endif

/* test/lc3b_core_tb.sv */
`default_nettype none

module lc3b_core_tb
    import lc3b_isa_pkg::*, lc3b_core_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int RESET_CYCLES = 3;

    logic              clk;
    logic              rst;
    logic [WORD_W-1:0] instr_address;
    logic [WORD_W-1:0] instr_rdata;
    logic              mem_write;
    logic [WORD_W-1:0] mem_address;
    logic [WORD_W-1:0] mem_wdata;
    logic [CNT_W-1:0]  instr_count;
    logic [CNT_W-1:0]  branch_count;

    lc3b_instr_t       program_words[$];  // ROM image from RESET_PC
    logic [WORD_W-1:0] exp_address[$];
    logic [WORD_W-1:0] exp_wdata[$];
    logic [CNT_W-1:0]  exp_instr_count[$];
    logic [CNT_W-1:0]  exp_branch_count[$];
    int                row;  // next expected store
    int                cycle_count;
    int                cycle_limit;

    lc3b_core lc3b_core_inst (
        .clk(clk), .rst(rst),
        .instr_address(instr_address), .instr_rdata(instr_rdata),
        .mem_write(mem_write), .mem_address(mem_address), .mem_wdata(mem_wdata),
        .instr_count(instr_count), .branch_count(branch_count)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic lc3b_instr_t alu_reg_word(input logic [3:0] opcode,
            input logic [REG_W-1:0] dest, input logic [REG_W-1:0] src1,
            input logic [REG_W-1:0] src2);
        lc3b_instr_t w;
        w.op.opcode   = opcode;
        w.op.dest     = dest;
        w.op.src1     = src1;
        w.op.imm_flag = 1'b0;
        w.op.tail     = {2'b00, src2};
        return w;
    endfunction

    function automatic lc3b_instr_t alu_imm_word(input logic [3:0] opcode,
            input logic [REG_W-1:0] dest, input logic [REG_W-1:0] src1, input int imm);
        lc3b_instr_t w;
        w.op.opcode   = opcode;
        w.op.dest     = dest;
        w.op.src1     = src1;
        w.op.imm_flag = 1'b1;
        w.op.tail     = 5'(imm);  // imm5, two's complement
        return w;
    endfunction

    function automatic lc3b_instr_t not_word(input logic [REG_W-1:0] dest,
            input logic [REG_W-1:0] src);
        lc3b_instr_t w;
        w.op.opcode   = OP_NOT;
        w.op.dest     = dest;
        w.op.src1     = src;
        w.op.imm_flag = 1'b1;
        w.op.tail     = 5'b11111;
        return w;
    endfunction

    function automatic lc3b_instr_t branch_word(input logic [2:0] nzp, input int offset9);
        lc3b_instr_t w;
        w.off.opcode = OP_BR;
        w.off.nzp    = nzp;
        {w.off.base, w.off.offset6} = 9'(offset9);  // in words from PC+2
        return w;
    endfunction

    function automatic lc3b_instr_t store_word(input logic [REG_W-1:0] src,
            input logic [REG_W-1:0] base, input int offset6);
        lc3b_instr_t w;
        w.off.opcode  = OP_STR;
        w.off.nzp     = src;
        w.off.base    = base;
        w.off.offset6 = 6'(offset6);
        return w;
    endfunction

    task automatic append_word(input lc3b_instr_t w);
        program_words.push_back(w);
    endtask

    task automatic expect_store(input logic [WORD_W-1:0] address,
            input logic [WORD_W-1:0] wdata, input logic [CNT_W-1:0] icount,
            input logic [CNT_W-1:0] bcount);
        exp_address.push_back(address);
        exp_wdata.push_back(wdata);
        exp_instr_count.push_back(icount);
        exp_branch_count.push_back(bcount);
    endtask

`include "lc3b_program.svh"

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_word(input string name, input logic [WORD_W-1:0] got,
            input logic [WORD_W-1:0] expected);
        if (got !== expected)
            stop_with_failure($sformatf("Fail at %0d ns: %s is %h, expected %h",
                $time, name, got, expected));
    endtask

    task automatic check_count(input string name, input logic [CNT_W-1:0] got,
            input logic [CNT_W-1:0] expected);
        if (got !== expected)
            stop_with_failure($sformatf("Fail at %0d ns: %s is %0d, expected %0d",
                $time, name, got, expected));
    endtask

    task automatic check_flag(input string name, input logic got, input logic expected);
        if (got !== expected)
            stop_with_failure($sformatf("Fail at %0d ns: %s is %b, expected %b",
                $time, name, got, expected));
    endtask

    // ROM answers the current fetch address
    task automatic drive_rom();
        int index;
        index = (int'(instr_address) - int'(RESET_PC)) / 2;
        if (index < 0 || index >= program_words.size() || instr_address[0])
            stop_with_failure($sformatf("fetch from address %h, which is outside the program",
                instr_address));
        else
            instr_rdata = program_words[index];
    endtask

    task automatic verify_reset_state();
        check_word("instr_address", instr_address, RESET_PC);
        check_flag("mem_write", mem_write, 1'b0);
        check_count("instr_count", instr_count, '0);
        check_count("branch_count", branch_count, '0);
    endtask

    task automatic compare_store();
        check_word($sformatf("mem_address (store %0d)", row), mem_address, exp_address[row]);
        check_word($sformatf("mem_wdata (store %0d)", row), mem_wdata, exp_wdata[row]);
        check_count($sformatf("instr_count (store %0d)", row), instr_count,
            exp_instr_count[row]);
        check_count($sformatf("branch_count (store %0d)", row), branch_count,
            exp_branch_count[row]);
        row++;
    endtask

    initial
    begin
        rst         = 1'b1;
        instr_rdata = '0;
        row         = 0;
        load_program();
        load_expected();
        for (int c = 0; c < RESET_CYCLES; c++)
        begin
            @(posedge clk);
            #5;
            if (c == RESET_CYCLES - 1)
                rst = 1'b0;  // last check below is the first cycle out of reset
            drive_rom();
            @(negedge clk);
            verify_reset_state();
        end
        while (row < exp_address.size())
        begin
            @(posedge clk);
            #5;
            drive_rom();
            @(negedge clk);
            if (mem_write)
                compare_store();
        end
        $display("TEST PASSED");
        $finish;
    end

    initial
    begin
        cycle_count = 0;
        @(posedge clk);  // tables are loaded at time zero
        cycle_limit = 4 * program_words.size() + 20;
        while (cycle_count < cycle_limit)
        begin
            @(posedge clk);
            cycle_count++;
        end
        stop_with_failure($sformatf("timeout after %0d cycles with %0d of %0d stores seen",
            cycle_limit, row, exp_address.size()));
    end

endmodule

`default_nettype wire

/* lc3b_core.f */
+incdir+test
design/lc3b_isa_pkg.sv
design/lc3b_core_pkg.sv
design/regfile.sv
design/fetch_unit.sv
design/decode_unit.sv
design/execute_unit.sv
design/perf_counters.sv
design/lc3b_core.sv
test/lc3b_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile the lc3b_core testbench with Verilator and run it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f lc3b_core.f --top-module lc3b_core_tb
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

sim_out=$(./obj_dir/Vlc3b_core_tb 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "TEST PASSED"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
